// ==== Bender.yml ====
package:
  name: ooo_core

sources:
  - files:
      - hw/ooo_pkg.sv
      - hw/fu_if.sv
      - hw/dispatch_unit.sv
      - hw/alu_fu.sv
      - hw/cdb_arbiter.sv
      - hw/reorder_buffer.sv
      - hw/ooo_core.sv
  - target: simulation
    files:
      - sim/tb_ooo_core.sv

// ==== hw/alu_fu.sv ====
`timescale 1ns/1ps

module alu_fu (
    input  logic    clk,
    input  logic    rst,
    fu_issue_if.fu  issue,
    fu_result_if.fu result
);

    // Stage one
    logic           s1_valid;
    ooo_pkg::op_t   s1_op;
    ooo_pkg::data_t s1_a;
    ooo_pkg::data_t s1_b;
    ooo_pkg::tag_t  s1_tag;
    ooo_pkg::data_t alu_out;

    // Two-entry result queue
    ooo_pkg::tag_t  q_tag   [2];
    ooo_pkg::data_t q_value [2];
    logic           wr_ptr;
    logic           rd_ptr;
    logic [1:0]     q_count;
    logic           pop;

    always_comb begin
        case (s1_op)
            ooo_pkg::OP_ADD: alu_out = s1_a + s1_b;
            ooo_pkg::OP_SUB: alu_out = s1_a - s1_b;
            ooo_pkg::OP_AND: alu_out = s1_a & s1_b;
            ooo_pkg::OP_XOR: alu_out = s1_a ^ s1_b;
            default:         alu_out = s1_a;
        endcase
    end

    assign result.valid = (q_count != 2'd0);
    assign result.tag = q_tag[rd_ptr];
    assign result.value = q_value[rd_ptr];
    assign pop = result.valid && result.grant;
    // Slot frees once the bus takes the result
    assign issue.credit = pop;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            q_count <= 2'd0;
        end else begin
            s1_valid <= issue.valid;
            if (s1_valid) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            if (s1_valid && !pop) begin
                q_count <= q_count + 2'd1;
            end else if (!s1_valid && pop) begin
                q_count <= q_count - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        s1_op <= issue.op;
        s1_a <= issue.a;
        s1_b <= issue.b;
        s1_tag <= issue.tag;
        if (s1_valid) begin
            q_tag[wr_ptr] <= s1_tag;
            q_value[wr_ptr] <= alu_out;
        end
    end

endmodule

// ==== hw/cdb_arbiter.sv ====
`timescale 1ns/1ps

module cdb_arbiter (
    input  logic           clk,
    input  logic           rst,
    fu_result_if.arbiter   result [ooo_pkg::FU_COUNT],
    output logic           cdb_valid,
    output ooo_pkg::tag_t  cdb_tag,
    output ooo_pkg::data_t cdb_value
);

    logic [ooo_pkg::FU_COUNT-1:0] res_valid;
    logic [ooo_pkg::FU_COUNT-1:0] grant_vec;
    ooo_pkg::tag_t    res_tag   [ooo_pkg::FU_COUNT];
    ooo_pkg::data_t   res_value [ooo_pkg::FU_COUNT];
    ooo_pkg::fu_idx_t last_win;
    ooo_pkg::fu_idx_t win;
    ooo_pkg::fu_idx_t cand;

    for (genvar g = 0; g < ooo_pkg::FU_COUNT; g++) begin : g_port
        assign res_valid[g] = result[g].valid;
        assign res_tag[g] = result[g].tag;
        assign res_value[g] = result[g].value;
        assign result[g].grant = grant_vec[g];
    end

    // Search starts one past the last winner
    always_comb begin
        cdb_valid = 1'b0;
        win = last_win;
        cand = last_win;
        for (int k = 1; k <= ooo_pkg::FU_COUNT; k++) begin
            cand = ooo_pkg::fu_idx_t'((int'(last_win) + k) % ooo_pkg::FU_COUNT);
            if (!cdb_valid && res_valid[cand]) begin
                cdb_valid = 1'b1;
                win = cand;
            end
        end
        grant_vec = '0;
        grant_vec[win] = cdb_valid;
        cdb_tag = res_tag[win];
        cdb_value = res_value[win];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_win <= ooo_pkg::fu_idx_t'(ooo_pkg::FU_COUNT - 1);
        end else if (cdb_valid) begin
            last_win <= win;
        end
    end

endmodule

// ==== hw/dispatch_unit.sv ====
`timescale 1ns/1ps

module dispatch_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  ooo_pkg::op_t      in_op,
    input  ooo_pkg::reg_idx_t in_dst,
    input  ooo_pkg::reg_idx_t in_src_a,
    input  ooo_pkg::reg_idx_t in_src_b,
    input  ooo_pkg::data_t    in_imm,
    input  ooo_pkg::tag_t     alloc_tag,
    output ooo_pkg::tag_t     rob_read_tag_a,
    output ooo_pkg::tag_t     rob_read_tag_b,
    input  logic              rob_read_done_a,
    input  logic              rob_read_done_b,
    input  ooo_pkg::data_t    rob_read_value_a,
    input  ooo_pkg::data_t    rob_read_value_b,
    input  logic              cdb_valid,
    input  ooo_pkg::tag_t     cdb_tag,
    input  ooo_pkg::data_t    cdb_value,
    input  logic              retire_valid,
    input  ooo_pkg::reg_idx_t retire_dst,
    input  ooo_pkg::data_t    retire_value,
    input  ooo_pkg::tag_t     retire_tag,
    fu_issue_if.dispatch      issue [ooo_pkg::FU_COUNT]
);

    // Architectural state and rename table
    ooo_pkg::data_t regfile [ooo_pkg::REG_COUNT];
    logic [ooo_pkg::REG_COUNT-1:0] ren_pending;
    ooo_pkg::tag_t  ren_tag [ooo_pkg::REG_COUNT];

    // Reservation stations, indexed by reorder tag
    logic [ooo_pkg::ROB_DEPTH-1:0] rs_valid;
    logic [ooo_pkg::ROB_DEPTH-1:0] rs_rdy_a;
    logic [ooo_pkg::ROB_DEPTH-1:0] rs_rdy_b;
    ooo_pkg::op_t   rs_op    [ooo_pkg::ROB_DEPTH];
    ooo_pkg::data_t rs_a     [ooo_pkg::ROB_DEPTH];
    ooo_pkg::data_t rs_b     [ooo_pkg::ROB_DEPTH];
    ooo_pkg::tag_t  rs_tag_a [ooo_pkg::ROB_DEPTH];
    ooo_pkg::tag_t  rs_tag_b [ooo_pkg::ROB_DEPTH];

    // Source operand resolution
    ooo_pkg::reg_idx_t src_reg  [2];
    logic              rob_done [2];
    ooo_pkg::data_t    rob_val  [2];
    ooo_pkg::tag_t     src_tag  [2];
    logic              src_rdy  [2];
    ooo_pkg::data_t    src_val  [2];

    // Issue selection
    logic [ooo_pkg::CREDIT_W-1:0] credits [ooo_pkg::FU_COUNT];
    logic [ooo_pkg::FU_COUNT-1:0] credit_ret;
    logic [ooo_pkg::FU_COUNT-1:0] issue_vec;
    ooo_pkg::fu_idx_t issue_rr;
    ooo_pkg::fu_idx_t issue_fu;
    ooo_pkg::fu_idx_t fu_cand;
    ooo_pkg::tag_t    issue_sel;
    logic             rs_found;
    logic             fu_found;
    logic             issue_fire;

    assign src_reg[0] = in_src_a;
    assign src_reg[1] = in_src_b;
    assign rob_done[0] = rob_read_done_a;
    assign rob_done[1] = rob_read_done_b;
    assign rob_val[0] = rob_read_value_a;
    assign rob_val[1] = rob_read_value_b;
    assign rob_read_tag_a = ren_tag[in_src_a];
    assign rob_read_tag_b = ren_tag[in_src_b];

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            src_tag[s] = ren_tag[src_reg[s]];
            src_rdy[s] = 1'b1;
            src_val[s] = regfile[src_reg[s]];
            if (ren_pending[src_reg[s]]) begin
                // Retiring this cycle, ROB slot already released
                if (retire_valid && retire_tag == src_tag[s]) begin
                    src_val[s] = retire_value;
                end else if (rob_done[s]) begin
                    src_val[s] = rob_val[s];
                end else if (cdb_valid && cdb_tag == src_tag[s]) begin
                    src_val[s] = cdb_value;
                end else begin
                    src_rdy[s] = 1'b0;
                    src_val[s] = '0;
                end
            end
        end
        if (in_op == ooo_pkg::OP_LDI) begin
            src_rdy[0] = 1'b1;
            src_val[0] = in_imm;
            src_rdy[1] = 1'b1;
        end
    end

    // ============================================================
    // Issue select
    // ============================================================
    always_comb begin
        rs_found = 1'b0;
        issue_sel = '0;
        for (int i = ooo_pkg::ROB_DEPTH - 1; i >= 0; i--) begin
            if (rs_valid[i] && rs_rdy_a[i] && rs_rdy_b[i]) begin
                rs_found = 1'b1;
                issue_sel = ooo_pkg::tag_t'(i);
            end
        end
    end

    always_comb begin
        fu_found = 1'b0;
        issue_fu = issue_rr;
        fu_cand = issue_rr;
        for (int k = 0; k < ooo_pkg::FU_COUNT; k++) begin
            fu_cand = ooo_pkg::fu_idx_t'((int'(issue_rr) + k) % ooo_pkg::FU_COUNT);
            if (!fu_found && credits[fu_cand] != '0) begin
                fu_found = 1'b1;
                issue_fu = fu_cand;
            end
        end
    end

    assign issue_fire = rs_found && fu_found;

    for (genvar g = 0; g < ooo_pkg::FU_COUNT; g++) begin : g_issue
        assign issue_vec[g] = issue_fire && (issue_fu == ooo_pkg::fu_idx_t'(g));
        assign issue[g].valid = issue_vec[g];
        assign issue[g].op = rs_op[issue_sel];
        assign issue[g].a = rs_a[issue_sel];
        assign issue[g].b = rs_b[issue_sel];
        assign issue[g].tag = issue_sel;
        assign credit_ret[g] = issue[g].credit;
    end

    // ============================================================
    // Control state
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < ooo_pkg::REG_COUNT; r++) begin
                regfile[r] <= '0;
            end
            ren_pending <= '0;
            rs_valid <= '0;
            issue_rr <= '0;
            for (int g = 0; g < ooo_pkg::FU_COUNT; g++) begin
                credits[g] <= ooo_pkg::CREDIT_W'(ooo_pkg::FU_CREDITS);
            end
        end else begin
            if (retire_valid) begin
                regfile[retire_dst] <= retire_value;
                if (ren_tag[retire_dst] == retire_tag) begin
                    ren_pending[retire_dst] <= 1'b0;
                end
            end
            // A new writer of the same register wins over the retire clear
            if (in_valid) begin
                ren_pending[in_dst] <= 1'b1;
                rs_valid[alloc_tag] <= 1'b1;
            end
            if (issue_fire) begin
                rs_valid[issue_sel] <= 1'b0;
                issue_rr <= ooo_pkg::fu_idx_t'((int'(issue_fu) + 1) % ooo_pkg::FU_COUNT);
            end
            for (int g = 0; g < ooo_pkg::FU_COUNT; g++) begin
                if (issue_vec[g] && !credit_ret[g]) begin
                    credits[g] <= credits[g] - 1'b1;
                end else if (!issue_vec[g] && credit_ret[g]) begin
                    credits[g] <= credits[g] + 1'b1;
                end
            end
        end
    end

    // Operand capture, wakeup from the bus
    always_ff @(posedge clk) begin
        for (int i = 0; i < ooo_pkg::ROB_DEPTH; i++) begin
            if (cdb_valid && !rs_rdy_a[i] && rs_tag_a[i] == cdb_tag) begin
                rs_rdy_a[i] <= 1'b1;
                rs_a[i] <= cdb_value;
            end
            if (cdb_valid && !rs_rdy_b[i] && rs_tag_b[i] == cdb_tag) begin
                rs_rdy_b[i] <= 1'b1;
                rs_b[i] <= cdb_value;
            end
        end
        if (in_valid) begin
            ren_tag[in_dst] <= alloc_tag;
            rs_op[alloc_tag] <= in_op;
            rs_rdy_a[alloc_tag] <= src_rdy[0];
            rs_rdy_b[alloc_tag] <= src_rdy[1];
            rs_a[alloc_tag] <= src_val[0];
            rs_b[alloc_tag] <= src_val[1];
            rs_tag_a[alloc_tag] <= src_tag[0];
            rs_tag_b[alloc_tag] <= src_tag[1];
        end
    end

endmodule

// ==== hw/fu_if.sv ====
`timescale 1ns/1ps

// Dispatch to functional unit
interface fu_issue_if;
    logic           valid;
    ooo_pkg::op_t   op;
    ooo_pkg::data_t a;
    ooo_pkg::data_t b;
    ooo_pkg::tag_t  tag;
    // One-cycle pulse, gives one issue slot back
    logic           credit;

    modport dispatch (output valid, op, a, b, tag, input credit);
    modport fu (input valid, op, a, b, tag, output credit);
endinterface

// Functional unit result queue head to the arbiter
interface fu_result_if;
    logic           valid;
    ooo_pkg::tag_t  tag;
    ooo_pkg::data_t value;
    logic           grant;

    modport fu (output valid, tag, value, input grant);
    modport arbiter (input valid, tag, value, output grant);
endinterface

// ==== hw/ooo_core.sv ====
`timescale 1ns/1ps

module ooo_core (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  ooo_pkg::op_t      in_op,
    input  ooo_pkg::reg_idx_t in_dst,
    input  ooo_pkg::reg_idx_t in_src_a,
    input  ooo_pkg::reg_idx_t in_src_b,
    input  ooo_pkg::data_t    in_imm,
    output logic              retire_valid,
    output ooo_pkg::reg_idx_t retire_dst,
    output ooo_pkg::data_t    retire_value
);

    ooo_pkg::tag_t  alloc_tag;
    ooo_pkg::tag_t  rob_read_tag_a;
    ooo_pkg::tag_t  rob_read_tag_b;
    logic           rob_read_done_a;
    logic           rob_read_done_b;
    ooo_pkg::data_t rob_read_value_a;
    ooo_pkg::data_t rob_read_value_b;
    logic           cdb_valid;
    ooo_pkg::tag_t  cdb_tag;
    ooo_pkg::data_t cdb_value;
    ooo_pkg::tag_t  retire_tag;

    fu_issue_if  issue_bus  [ooo_pkg::FU_COUNT] ();
    fu_result_if result_bus [ooo_pkg::FU_COUNT] ();

    dispatch_unit u_dispatch (
        .clk, .rst, .in_valid, .in_op, .in_dst, .in_src_a, .in_src_b, .in_imm,
        .alloc_tag, .rob_read_tag_a, .rob_read_tag_b,
        .rob_read_done_a, .rob_read_done_b, .rob_read_value_a, .rob_read_value_b,
        .cdb_valid, .cdb_tag, .cdb_value,
        .retire_valid, .retire_dst, .retire_value, .retire_tag,
        .issue(issue_bus)
    );

    for (genvar g = 0; g < ooo_pkg::FU_COUNT; g++) begin : g_alu
        alu_fu u_alu (
            .clk, .rst, .issue(issue_bus[g]), .result(result_bus[g])
        );
    end

    cdb_arbiter u_arbiter (
        .clk, .rst, .result(result_bus), .cdb_valid, .cdb_tag, .cdb_value
    );

    reorder_buffer u_rob (
        .clk, .rst, .in_valid, .in_dst, .alloc_tag,
        .read_tag_a(rob_read_tag_a), .read_tag_b(rob_read_tag_b),
        .read_done_a(rob_read_done_a), .read_done_b(rob_read_done_b),
        .read_value_a(rob_read_value_a), .read_value_b(rob_read_value_b),
        .cdb_valid, .cdb_tag, .cdb_value,
        .retire_valid, .retire_dst, .retire_value, .retire_tag
    );

endmodule

// ==== hw/ooo_pkg.sv ====
package ooo_pkg;

    // ============================================================
    // Sizes
    // ============================================================
    localparam int DATA_W     = 8;
    localparam int REG_COUNT  = 8;
    localparam int ROB_DEPTH  = 8;
    localparam int FU_COUNT   = 3;
    localparam int FU_CREDITS = 2;

    // Derived widths
    localparam int REG_IDX_W = $clog2(REG_COUNT);
    localparam int TAG_W     = $clog2(ROB_DEPTH);
    localparam int FU_IDX_W  = 2;
    localparam int CREDIT_W  = $clog2(FU_CREDITS + 1);

    // ============================================================
    // Types
    // ============================================================
    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [TAG_W-1:0]     tag_t;
    typedef logic [FU_IDX_W-1:0]  fu_idx_t;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_XOR,
        OP_LDI
    } op_t;

endpackage

// ==== hw/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  ooo_pkg::reg_idx_t in_dst,
    output ooo_pkg::tag_t     alloc_tag,
    input  ooo_pkg::tag_t     read_tag_a,
    input  ooo_pkg::tag_t     read_tag_b,
    output logic              read_done_a,
    output logic              read_done_b,
    output ooo_pkg::data_t    read_value_a,
    output ooo_pkg::data_t    read_value_b,
    input  logic              cdb_valid,
    input  ooo_pkg::tag_t     cdb_tag,
    input  ooo_pkg::data_t    cdb_value,
    output logic              retire_valid,
    output ooo_pkg::reg_idx_t retire_dst,
    output ooo_pkg::data_t    retire_value,
    output ooo_pkg::tag_t     retire_tag
);

    ooo_pkg::reg_idx_t rob_dst   [ooo_pkg::ROB_DEPTH];
    ooo_pkg::data_t    rob_value [ooo_pkg::ROB_DEPTH];
    logic [ooo_pkg::ROB_DEPTH-1:0] rob_done;
    ooo_pkg::tag_t head;
    ooo_pkg::tag_t tail;
    logic          head_done;

    assign alloc_tag = tail;
    assign head_done = rob_done[head];

    // Completed-value lookup for dispatch
    assign read_done_a = rob_done[read_tag_a];
    assign read_done_b = rob_done[read_tag_b];
    assign read_value_a = rob_value[read_tag_a];
    assign read_value_b = rob_value[read_tag_b];

    // ============================================================
    // Pointers and completion
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            rob_done <= '0;
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= head_done;
            if (head_done) begin
                rob_done[head] <= 1'b0;
                head <= head + 1'b1;
            end
            if (cdb_valid) begin
                rob_done[cdb_tag] <= 1'b1;
            end
            if (in_valid) begin
                rob_done[tail] <= 1'b0;
                tail <= tail + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            rob_dst[tail] <= in_dst;
        end
        if (cdb_valid) begin
            rob_value[cdb_tag] <= cdb_value;
        end
        if (head_done) begin
            retire_dst <= rob_dst[head];
            retire_value <= rob_value[head];
            retire_tag <= head;
        end
    end

endmodule

// ==== ooo_core.f ====
hw/ooo_pkg.sv
hw/fu_if.sv
hw/dispatch_unit.sv
hw/alu_fu.sv
hw/cdb_arbiter.sv
hw/reorder_buffer.sv
hw/ooo_core.sv
sim/tb_ooo_core.sv

// ==== sim/tb_ooo_core.sv ====
`timescale 1ns/1ps

module tb_ooo_core;

    logic              clk;
    logic              rst;
    logic              in_valid;
    ooo_pkg::op_t      in_op;
    ooo_pkg::reg_idx_t in_dst;
    ooo_pkg::reg_idx_t in_src_a;
    ooo_pkg::reg_idx_t in_src_b;
    ooo_pkg::data_t    in_imm;
    logic              retire_valid;
    ooo_pkg::reg_idx_t retire_dst;
    ooo_pkg::data_t    retire_value;

    // Reference model
    ooo_pkg::data_t    model_regs [ooo_pkg::REG_COUNT];
    ooo_pkg::reg_idx_t exp_dst [$];
    ooo_pkg::data_t    exp_val [$];

    int          credits;
    int          sent_count;
    int          retire_count;
    int          check_count;
    int          error_count;
    int          cycle_count;
    logic [31:0] rng_state;

    ooo_core dut (
        .clk, .rst, .in_valid, .in_op, .in_dst, .in_src_a, .in_src_b, .in_imm,
        .retire_valid, .retire_dst, .retire_value
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Watchdog, allowance grows with every instruction sent
    initial begin
        cycle_count = 0;
        while (cycle_count <= 40 * sent_count + 200) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, %0d of %0d instructions retired",
                 cycle_count, retire_count, sent_count);
        $display("Simulation FAILED");
        $finish;
    end

    // ============================================================
    // Helpers
    // ============================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic ooo_pkg::data_t compute_expected(input ooo_pkg::op_t op,
            input ooo_pkg::data_t a, input ooo_pkg::data_t b, input ooo_pkg::data_t imm);
        case (op)
            ooo_pkg::OP_ADD: return a + b;
            ooo_pkg::OP_SUB: return a - b;
            ooo_pkg::OP_AND: return a & b;
            ooo_pkg::OP_XOR: return a ^ b;
            default:         return imm;
        endcase
    endfunction

    task automatic check_reg_idx(input ooo_pkg::reg_idx_t got, input ooo_pkg::reg_idx_t exp,
            input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_data(input ooo_pkg::data_t got, input ooo_pkg::data_t exp,
            input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s is 0x%02h, expected 0x%02h",
                     $time, what, got, exp);
        end
    endtask

    task automatic take_retire();
        ooo_pkg::reg_idx_t dst;
        ooo_pkg::data_t    value;
        credits++;
        retire_count++;
        if (exp_dst.size() == 0) begin
            error_count++;
            $display("Retire at %0t with no instruction outstanding", $time);
        end else begin
            dst = exp_dst.pop_front();
            value = exp_val.pop_front();
            check_reg_idx(retire_dst, dst, "retire_dst");
            check_data(retire_value, value, "retire_value");
        end
    endtask

    // One clock, outputs sampled and inputs free to change afterwards
    task automatic step();
        @(posedge clk);
        #1;
        if (retire_valid === 1'b1) begin
            take_retire();
        end
    endtask

    task automatic idle(input int n);
        repeat (n) step();
    endtask

    task automatic send_instr(input ooo_pkg::op_t op, input ooo_pkg::reg_idx_t dst,
            input ooo_pkg::reg_idx_t src_a, input ooo_pkg::reg_idx_t src_b,
            input ooo_pkg::data_t imm);
        ooo_pkg::data_t value;
        while (credits == 0) begin
            step();
        end
        value = compute_expected(op, model_regs[src_a], model_regs[src_b], imm);
        model_regs[dst] = value;
        exp_dst.push_back(dst);
        exp_val.push_back(value);
        in_valid = 1'b1;
        in_op = op;
        in_dst = dst;
        in_src_a = src_a;
        in_src_b = src_b;
        in_imm = imm;
        credits--;
        sent_count++;
        step();
        in_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_dst.size() != 0 || credits != ooo_pkg::ROB_DEPTH) begin
            step();
        end
    endtask

    // ============================================================
    // Tests
    // ============================================================
    task automatic test_load_all();
        for (int r = 0; r < ooo_pkg::REG_COUNT; r++) begin
            send_instr(ooo_pkg::OP_LDI, 3'(r), 3'(0), 3'(0), 8'(r * 37 + 5));
        end
        wait_drained();
    endtask

    task automatic test_dependent_chain();
        ooo_pkg::op_t ops [4];
        ops = '{ooo_pkg::OP_ADD, ooo_pkg::OP_SUB, ooo_pkg::OP_XOR, ooo_pkg::OP_AND};
        send_instr(ooo_pkg::OP_LDI, 3'd1, 3'd0, 3'd0, 8'hf3);
        for (int i = 0; i < 12; i++) begin
            // Source a is always the previous destination
            send_instr(ops[i % 4], 3'((i + 2) % 8), 3'((i + 1) % 8), 3'(i % 8), 8'h00);
            // Gaps let the producer finish and park in the reorder buffer
            if (i % 3 == 2) begin
                idle(6);
            end
        end
        wait_drained();
    endtask

    task automatic test_full_burst();
        wait_drained();
        for (int i = 0; i < ooo_pkg::ROB_DEPTH; i++) begin
            if (i % 2 == 0) begin
                send_instr(ooo_pkg::OP_LDI, 3'(i), 3'(0), 3'(0), 8'(8'h81 + i * 19));
            end else begin
                send_instr(ooo_pkg::OP_ADD, 3'(i), 3'(i - 1), 3'(i), 8'h00);
            end
        end
        wait_drained();
        idle(20);
    endtask

    task automatic test_all_ops();
        ooo_pkg::op_t ops [4];
        ops = '{ooo_pkg::OP_ADD, ooo_pkg::OP_SUB, ooo_pkg::OP_AND, ooo_pkg::OP_XOR};
        send_instr(ooo_pkg::OP_LDI, 3'd6, 3'd0, 3'd0, 8'hc8);
        send_instr(ooo_pkg::OP_LDI, 3'd7, 3'd0, 3'd0, 8'h5a);
        for (int i = 0; i < 4; i++) begin
            send_instr(ops[i], 3'(i), 3'd6, 3'd7, 8'h00);
            send_instr(ops[i], 3'((i + 4) % 6), 3'd7, 3'd6, 8'h00);
        end
        wait_drained();
    endtask

    task automatic test_random_stream();
        ooo_pkg::op_t op;
        rng_state = 32'h4cfb_9006;
        for (int i = 0; i < 200; i++) begin
            rng_state = xorshift32(rng_state);
            op = ooo_pkg::op_t'(3'(rng_state[31:8] % 5));
            send_instr(op, rng_state[2:0], rng_state[5:3], rng_state[8:6],
                       rng_state[23:16]);
        end
        wait_drained();
        idle(20);
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        rst = 1'b1;
        in_valid = 1'b0;
        in_op = ooo_pkg::OP_ADD;
        in_dst = '0;
        in_src_a = '0;
        in_src_b = '0;
        in_imm = '0;
        credits = ooo_pkg::ROB_DEPTH;
        sent_count = 0;
        retire_count = 0;
        check_count = 0;
        error_count = 0;
        for (int r = 0; r < ooo_pkg::REG_COUNT; r++) begin
            model_regs[r] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        test_load_all();
        test_dependent_chain();
        test_full_burst();
        test_all_ops();
        test_random_stream();
        $display("Sent %0d, retired %0d, checks %0d, errors %0d",
                 sent_count, retire_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
